// ==== logic/host_bus_pkg.sv ====
package host_bus_pkg;

    // host register bus geometry
    localparam int REG_ADDR_W = 16;
    localparam int REG_DATA_W = 64;

    // word offset inside one channel bank
    localparam int OFS_W = 2;

    localparam logic [OFS_W-1:0] OFS_CTRL = 2'd0;
    localparam logic [OFS_W-1:0] OFS_TX   = 2'd1;
    // read only: rx word in 17..0, loss flag in 18
    localparam logic [OFS_W-1:0] OFS_RX   = 2'd2;

    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] waddr;
        logic [REG_DATA_W-1:0] wdata;
    } reg_wr_t;

    typedef struct packed {
        logic                  ren;
        logic [REG_ADDR_W-1:0] raddr;
    } reg_rd_t;

    // write already steered to one bank
    typedef struct packed {
        logic                  strobe;
        logic [OFS_W-1:0]      offset;
        logic [REG_DATA_W-1:0] data;
    } bank_wr_t;

endpackage

// ==== logic/tlk_pkg.sv ====
package tlk_pkg;

    // received symbol as it comes off the tlk2711 pins
    typedef struct packed {
        logic        rkmsb;
        logic        rklsb;
        logic [15:0] rxd;
    } rx_word_t;

    typedef struct packed {
        logic        tkmsb;
        logic        tklsb;
        logic [15:0] txd;
    } tx_word_t;

    // phy control pins
    typedef struct packed {
        logic enable;
        logic loopen;
        logic prbsen;
        logic testen;
        logic pre;
        logic lckrefn;
    } link_ctrl_t;

    // host write word seen as control register
    typedef struct packed {
        logic [host_bus_pkg::REG_DATA_W-$bits(link_ctrl_t)-1:0] pad;
        link_ctrl_t                                             ctrl;
    } ctrl_view_t;

    // host write word seen as tx symbol
    typedef struct packed {
        logic [host_bus_pkg::REG_DATA_W-$bits(tx_word_t)-1:0] pad;
        tx_word_t                                             tx;
    } tx_view_t;

    typedef union packed {
        ctrl_view_t ctrl_view;
        tx_view_t   tx_view;
    } reg_word_u;

    // refclk lock held off, everything else low
    localparam link_ctrl_t CTRL_RESET = '{
        enable:  1'b0,
        loopen:  1'b0,
        prbsen:  1'b0,
        testen:  1'b0,
        pre:     1'b0,
        lckrefn: 1'b1
    };

endpackage

// ==== logic/board_support.sv ====
module board_support #(
    parameter int LED_DIV_BIT   = 26,
    parameter int PHY_RST_WIDTH = 16
) (
    input  logic clk_100,
    input  logic i_rst_n,
    output logic o_usr_led,
    output logic o_phy_resetn
);

    logic [LED_DIV_BIT:0]   led_cnt;
    logic [PHY_RST_WIDTH-1:0] phy_rst_cnt;

    // free running heartbeat divider
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            led_cnt <= '0;
        end else begin
            led_cnt <= led_cnt + 1'b1;
        end
    end

    assign o_usr_led = led_cnt[LED_DIV_BIT];

    // saturates at all ones, which releases the ethernet phy
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            phy_rst_cnt <= '0;
        end else if (!(&phy_rst_cnt)) begin
            phy_rst_cnt <= phy_rst_cnt + 1'b1;
        end
    end

    assign o_phy_resetn = &phy_rst_cnt;

endmodule

// ==== logic/tlk_rx_sync.sv ====
module tlk_rx_sync #(
    parameter int RX_SYNC_STAGES = 2,
    parameter int LOSS_LIMIT     = 1024
) (
    input  logic              i_rx_clk,
    input  logic              clk_100,
    input  logic              i_rst_n,
    input  tlk_pkg::rx_word_t i_rx,
    output tlk_pkg::rx_word_t o_rx,
    output logic              o_loss
);

    import tlk_pkg::*;

    localparam int CNT_W = $clog2(LOSS_LIMIT + 1);

    rx_word_t          rx_pin_q;
    rx_word_t          sync_q [RX_SYNC_STAGES];
    logic              k_seen;
    logic [CNT_W-1:0]  nok_cnt;
    logic              loss_q;

    // first capture in the recovered clock domain
    always_ff @(posedge i_rx_clk) begin
        rx_pin_q <= i_rx;
    end

    // rx clock is frequency locked to clk_100, plain register chain
    always_ff @(posedge clk_100) begin
        sync_q[0] <= rx_pin_q;
        for (int i = 1; i < RX_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign o_rx   = sync_q[RX_SYNC_STAGES-1];
    assign k_seen = o_rx.rkmsb | o_rx.rklsb;

    // count words without any k character
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            nok_cnt <= '0;
            loss_q  <= 1'b0;
        end else if (k_seen) begin
            nok_cnt <= '0;
            loss_q  <= 1'b0;
        end else if (nok_cnt != CNT_W'(LOSS_LIMIT)) begin
            nok_cnt <= nok_cnt + 1'b1;
            // limit reached with this word
            if (nok_cnt == CNT_W'(LOSS_LIMIT - 1)) begin
                loss_q <= 1'b1;
            end
        end
    end

    assign o_loss = loss_q;

endmodule

// ==== logic/link_ctrl_regs.sv ====
module link_ctrl_regs (
    input  logic                                clk_100,
    input  logic                                i_rst_n,
    input  host_bus_pkg::bank_wr_t              i_wr,
    input  logic [host_bus_pkg::OFS_W-1:0]      i_rd_ofs,
    input  tlk_pkg::rx_word_t                   i_rx,
    input  logic                                i_loss,
    output logic [host_bus_pkg::REG_DATA_W-1:0] o_rd_word,
    output tlk_pkg::link_ctrl_t                 o_ctrl,
    output tlk_pkg::tx_word_t                   o_tx
);

    import host_bus_pkg::*;
    import tlk_pkg::*;

    localparam int CTRL_W = $bits(link_ctrl_t);
    localparam int TX_W   = $bits(tx_word_t);
    localparam int RX_W   = $bits(rx_word_t);

    reg_word_u  wr_word;
    link_ctrl_t ctrl_q;
    tx_word_t   tx_q;
    logic [REG_DATA_W-1:0] rd_word;

    assign wr_word = i_wr.data;

    // offset picks which view of the host word applies
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            ctrl_q <= CTRL_RESET;
            tx_q   <= '0;
        end else if (i_wr.strobe) begin
            case (i_wr.offset)
                OFS_CTRL: ctrl_q <= wr_word.ctrl_view.ctrl;
                OFS_TX:   tx_q   <= wr_word.tx_view.tx;
                // rx status is read only
                default: ;
            endcase
        end
    end

    assign o_ctrl = ctrl_q;
    assign o_tx   = tx_q;

    // combinational read word, decoder registers it
    always_comb begin
        rd_word = '0;
        case (i_rd_ofs)
            OFS_CTRL: begin
                rd_word[CTRL_W-1:0] = ctrl_q;
            end
            OFS_TX: begin
                rd_word[TX_W-1:0] = tx_q;
            end
            OFS_RX: begin
                rd_word[RX_W-1:0] = i_rx;
                // loss flag sits just above the rx word
                rd_word[RX_W]     = i_loss;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    assign o_rd_word = rd_word;

endmodule

// ==== logic/host_reg_decode.sv ====
module host_reg_decode #(
    parameter logic [host_bus_pkg::REG_ADDR_W-1:0] CH_A_BASE    = 16'h0100,
    parameter logic [host_bus_pkg::REG_ADDR_W-1:0] CH_B_BASE    = 16'h0000,
    parameter logic [host_bus_pkg::REG_ADDR_W-1:0] CH_ADDR_MASK = 16'h00ff
) (
    input  logic                                clk_100,
    input  logic                                i_rst_n,
    input  host_bus_pkg::reg_wr_t               i_reg_wr,
    input  host_bus_pkg::reg_rd_t               i_reg_rd,
    input  logic [host_bus_pkg::REG_DATA_W-1:0] i_a_rd_word,
    input  logic [host_bus_pkg::REG_DATA_W-1:0] i_b_rd_word,
    output host_bus_pkg::bank_wr_t              o_a_wr,
    output host_bus_pkg::bank_wr_t              o_b_wr,
    output logic [host_bus_pkg::OFS_W-1:0]      o_rd_ofs,
    output logic [host_bus_pkg::REG_DATA_W-1:0] o_reg_rdata
);

    import host_bus_pkg::*;

    logic                  wr_hit_a, wr_hit_b;
    logic                  rd_hit_a, rd_hit_b;
    logic                  a_stb_q, b_stb_q;
    logic [OFS_W-1:0]      wr_ofs_q;
    logic [REG_DATA_W-1:0] wr_data_q;
    logic                  rd_pend_q, rd_sel_a_q, rd_sel_b_q;
    logic [OFS_W-1:0]      rd_ofs_q;
    logic [REG_DATA_W-1:0] rdata_q;

    // bits outside the mask must match the channel base
    assign wr_hit_a = (i_reg_wr.waddr & ~CH_ADDR_MASK) == CH_A_BASE;
    assign wr_hit_b = (i_reg_wr.waddr & ~CH_ADDR_MASK) == CH_B_BASE;
    assign rd_hit_a = (i_reg_rd.raddr & ~CH_ADDR_MASK) == CH_A_BASE;
    assign rd_hit_b = (i_reg_rd.raddr & ~CH_ADDR_MASK) == CH_B_BASE;

    // write strobes, a miss strobes neither bank
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            a_stb_q <= 1'b0;
            b_stb_q <= 1'b0;
        end else begin
            a_stb_q <= i_reg_wr.wen & wr_hit_a;
            b_stb_q <= i_reg_wr.wen & wr_hit_b;
        end
    end

    always_ff @(posedge clk_100) begin
        wr_ofs_q  <= i_reg_wr.waddr[OFS_W-1:0];
        wr_data_q <= i_reg_wr.wdata;
    end

    assign o_a_wr = '{strobe: a_stb_q, offset: wr_ofs_q, data: wr_data_q};
    assign o_b_wr = '{strobe: b_stb_q, offset: wr_ofs_q, data: wr_data_q};

    // read stage 1: latch offset and bank select
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            rd_pend_q  <= 1'b0;
            rd_sel_a_q <= 1'b0;
            rd_sel_b_q <= 1'b0;
        end else begin
            rd_pend_q  <= i_reg_rd.ren;
            rd_sel_a_q <= rd_hit_a;
            rd_sel_b_q <= rd_hit_b & ~rd_hit_a;
        end
    end

    always_ff @(posedge clk_100) begin
        if (i_reg_rd.ren) begin
            rd_ofs_q <= i_reg_rd.raddr[OFS_W-1:0];
        end
    end

    assign o_rd_ofs = rd_ofs_q;

    // read stage 2: capture selected bank, held until next read
    always_ff @(posedge clk_100) begin
        if (!i_rst_n) begin
            rdata_q <= '0;
        end else if (rd_pend_q) begin
            rdata_q <= rd_sel_a_q ? i_a_rd_word :
                       rd_sel_b_q ? i_b_rd_word : '0;
        end
    end

    assign o_reg_rdata = rdata_q;

endmodule

// ==== logic/serdes_top.sv ====
module serdes_top #(
    parameter logic [host_bus_pkg::REG_ADDR_W-1:0] CH_A_BASE    = 16'h0100,
    parameter logic [host_bus_pkg::REG_ADDR_W-1:0] CH_B_BASE    = 16'h0000,
    parameter logic [host_bus_pkg::REG_ADDR_W-1:0] CH_ADDR_MASK = 16'h00ff,
    parameter int RX_SYNC_STAGES = 2,
    parameter int LOSS_LIMIT     = 1024,
    parameter int LED_DIV_BIT    = 26,
    parameter int PHY_RST_WIDTH  = 16
) (
    input  logic                                clk_100,
    input  logic                                i_rst_n,
    input  host_bus_pkg::reg_wr_t               i_reg_wr,
    input  host_bus_pkg::reg_rd_t               i_reg_rd,
    input  logic                                i_a_rx_clk,
    input  logic                                i_b_rx_clk,
    input  tlk_pkg::rx_word_t                   i_a_rx,
    input  tlk_pkg::rx_word_t                   i_b_rx,
    output logic [host_bus_pkg::REG_DATA_W-1:0] o_reg_rdata,
    output tlk_pkg::tx_word_t                   o_a_tx,
    output tlk_pkg::tx_word_t                   o_b_tx,
    output tlk_pkg::link_ctrl_t                 o_a_ctrl,
    output tlk_pkg::link_ctrl_t                 o_b_ctrl,
    output logic                                o_a_loss_irq,
    output logic                                o_b_loss_irq,
    output logic                                o_usr_led,
    output logic                                o_phy_resetn
);

    import host_bus_pkg::*;
    import tlk_pkg::*;

    bank_wr_t              a_wr, b_wr;
    logic [OFS_W-1:0]      rd_ofs;
    logic [REG_DATA_W-1:0] a_rd_word, b_rd_word;
    rx_word_t              a_rx_sync, b_rx_sync;

    host_reg_decode #(
        .CH_A_BASE   (CH_A_BASE),
        .CH_B_BASE   (CH_B_BASE),
        .CH_ADDR_MASK(CH_ADDR_MASK)
    ) u_decode (
        .clk_100    (clk_100),
        .i_rst_n    (i_rst_n),
        .i_reg_wr   (i_reg_wr),
        .i_reg_rd   (i_reg_rd),
        .i_a_rd_word(a_rd_word),
        .i_b_rd_word(b_rd_word),
        .o_a_wr     (a_wr),
        .o_b_wr     (b_wr),
        .o_rd_ofs   (rd_ofs),
        .o_reg_rdata(o_reg_rdata)
    );

    // channel a
    tlk_rx_sync #(
        .RX_SYNC_STAGES(RX_SYNC_STAGES),
        .LOSS_LIMIT    (LOSS_LIMIT)
    ) u_a_rx (
        .i_rx_clk(i_a_rx_clk),
        .clk_100 (clk_100),
        .i_rst_n (i_rst_n),
        .i_rx    (i_a_rx),
        .o_rx    (a_rx_sync),
        .o_loss  (o_a_loss_irq)
    );

    link_ctrl_regs u_a_regs (
        .clk_100  (clk_100),
        .i_rst_n  (i_rst_n),
        .i_wr     (a_wr),
        .i_rd_ofs (rd_ofs),
        .i_rx     (a_rx_sync),
        .i_loss   (o_a_loss_irq),
        .o_rd_word(a_rd_word),
        .o_ctrl   (o_a_ctrl),
        .o_tx     (o_a_tx)
    );

    // channel b
    tlk_rx_sync #(
        .RX_SYNC_STAGES(RX_SYNC_STAGES),
        .LOSS_LIMIT    (LOSS_LIMIT)
    ) u_b_rx (
        .i_rx_clk(i_b_rx_clk),
        .clk_100 (clk_100),
        .i_rst_n (i_rst_n),
        .i_rx    (i_b_rx),
        .o_rx    (b_rx_sync),
        .o_loss  (o_b_loss_irq)
    );

    link_ctrl_regs u_b_regs (
        .clk_100  (clk_100),
        .i_rst_n  (i_rst_n),
        .i_wr     (b_wr),
        .i_rd_ofs (rd_ofs),
        .i_rx     (b_rx_sync),
        .i_loss   (o_b_loss_irq),
        .o_rd_word(b_rd_word),
        .o_ctrl   (o_b_ctrl),
        .o_tx     (o_b_tx)
    );

    board_support #(
        .LED_DIV_BIT  (LED_DIV_BIT),
        .PHY_RST_WIDTH(PHY_RST_WIDTH)
    ) u_board (
        .clk_100     (clk_100),
        .i_rst_n     (i_rst_n),
        .o_usr_led   (o_usr_led),
        .o_phy_resetn(o_phy_resetn)
    );

endmodule

// ==== verification/serdes_top_assert.sv ====
module serdes_top_assert (
    input logic                                clk_100,
    input logic                                i_rst_n,
    input logic                                i_reg_ren,
    input logic [host_bus_pkg::REG_DATA_W-1:0] i_reg_rdata,
    input logic                                i_phy_resetn,
    input logic                                i_a_wr_stb,
    input logic                                i_b_wr_stb
);

    // read data moves on the second edge after ren is sampled
    assert property (@(posedge clk_100) disable iff (!i_rst_n)
        (i_reg_rdata != $past(i_reg_rdata)) |-> $past(i_reg_ren, 2))
        else $error("read data changed without a read");

    // phy stays out of reset once released
    assert property (@(posedge clk_100) disable iff (!i_rst_n)
        $past(i_phy_resetn) |-> i_phy_resetn)
        else $error("phy reset fell while the board was out of reset");

    assert property (@(posedge clk_100) disable iff (!i_rst_n)
        !(i_a_wr_stb && i_b_wr_stb))
        else $error("write strobes to both banks at once");

endmodule

bind serdes_top serdes_top_assert u_assert (
    .clk_100     (clk_100),
    .i_rst_n     (i_rst_n),
    .i_reg_ren   (i_reg_rd.ren),
    .i_reg_rdata (o_reg_rdata),
    .i_phy_resetn(o_phy_resetn),
    .i_a_wr_stb  (a_wr.strobe),
    .i_b_wr_stb  (b_wr.strobe)
);

// ==== verification/tb_serdes_top.sv ====
module tb_serdes_top;

    import host_bus_pkg::*;
    import tlk_pkg::*;

    localparam int LED_DIV_BIT   = 3;
    localparam int PHY_RST_WIDTH = 5;
    localparam int RESET_CYCLES  = 10;
    // worst case cycles of one golden operation, a read
    localparam int OP_CYCLES     = 3;

    logic                  clk_100;
    logic                  i_rst_n;
    reg_wr_t               i_reg_wr;
    reg_rd_t               i_reg_rd;
    logic                  i_a_rx_clk, i_b_rx_clk;
    rx_word_t              i_a_rx, i_b_rx;
    logic [REG_DATA_W-1:0] o_reg_rdata;
    tx_word_t              o_a_tx, o_b_tx;
    link_ctrl_t            o_a_ctrl, o_b_ctrl;
    logic                  o_a_loss_irq, o_b_loss_irq;
    logic                  o_usr_led, o_phy_resetn;

    // golden operations, one entry per line of the file
    logic [63:0]  op_q[$];
    logic [191:0] name_q[$];
    logic [63:0]  arg_a_q[$];
    logic [63:0]  arg_b_q[$];
    int           errors;
    int           checks;
    int           cycles;
    int           limit;

    serdes_top #(
        .CH_A_BASE     (16'h0100),
        .CH_B_BASE     (16'h0000),
        .CH_ADDR_MASK  (16'h00ff),
        .RX_SYNC_STAGES(2),
        .LOSS_LIMIT    (8),
        .LED_DIV_BIT   (LED_DIV_BIT),
        .PHY_RST_WIDTH (PHY_RST_WIDTH)
    ) dut (.*);

    // rx clocks follow clk_100, the links run in loopback
    initial begin
        clk_100    = 1'b0;
        i_a_rx_clk = 1'b0;
        i_b_rx_clk = 1'b0;
        forever begin
            #2;
            clk_100    = ~clk_100;
            i_a_rx_clk = clk_100;
            i_b_rx_clk = clk_100;
        end
    end

    task automatic check_value(input logic [191:0] name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [63:0] pin_value(input logic [63:0] sel);
        case (sel)
            64'd0: return {58'd0, o_a_ctrl};
            64'd1: return {58'd0, o_b_ctrl};
            64'd2: return {46'd0, o_a_tx};
            64'd3: return {46'd0, o_b_tx};
            64'd4: return {63'd0, o_a_loss_irq};
            64'd5: return {63'd0, o_b_loss_irq};
            64'd6: return o_reg_rdata;
            // no such pin, never matches a golden value
            default: return '1;
        endcase
    endfunction

    task automatic load_golden(output int wait_sum);
        int               fd;
        int               code;
        logic [63:0]      op;
        logic [191:0]     name;
        logic [63:0]      a, b;
        logic [8*120-1:0] rest;
        wait_sum = 0;
        fd = $fopen("verification/serdes_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/serdes_golden.txt");
            errors++;
        end else begin
            code = $fscanf(fd, "%s", op);
            while (code == 1) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%s %h %h", name, a, b);
                    if (code != 3) begin
                        $display("golden file line after %0d entries is malformed", op_q.size());
                        errors++;
                    end
                    op_q.push_back(op);
                    name_q.push_back(name);
                    arg_a_q.push_back(a);
                    arg_b_q.push_back(b);
                    if (op == "wt") begin
                        wait_sum += int'(a);
                    end
                end
                code = $fscanf(fd, "%s", op);
            end
            $fclose(fd);
        end
    endtask

    // every operation starts and ends on a falling edge
    task automatic run_op(input logic [63:0] op, input logic [191:0] name,
                          input logic [63:0] a, input logic [63:0] b);
        if (op == "wr") begin
            i_reg_wr = '{wen: 1'b1, waddr: a[15:0], wdata: b};
            @(negedge clk_100);
            i_reg_wr.wen = 1'b0;
        end else if (op == "rd") begin
            i_reg_rd = '{ren: 1'b1, raddr: a[15:0]};
            @(negedge clk_100);
            i_reg_rd.ren = 1'b0;
            // bank word lands one edge after the select
            @(negedge clk_100);
            check_value(name, b, o_reg_rdata);
        end else if (op == "rx") begin
            if (a == 64'd0) begin
                i_a_rx = b[17:0];
            end else begin
                i_b_rx = b[17:0];
            end
        end else if (op == "wt") begin
            repeat (int'(a)) @(negedge clk_100);
        end else if (op == "pn") begin
            check_value(name, b, pin_value(a));
        end else begin
            $display("golden file holds an unknown operation in %0s", name);
            errors++;
        end
    endtask

    initial begin
        int wait_sum;
        errors   = 0;
        checks   = 0;
        limit    = 0;
        i_rst_n  = 1'b0;
        i_reg_wr = '0;
        i_reg_rd = '0;
        // k characters on both links, no loss pending at release
        i_a_rx   = 18'h2_50bc;
        i_b_rx   = 18'h2_50bc;
        load_golden(wait_sum);
        if (op_q.size() == 0) begin
            $display("golden file holds no operations");
            errors++;
        end
        limit = 4 * (RESET_CYCLES + wait_sum + OP_CYCLES * op_q.size());
        repeat (RESET_CYCLES) @(negedge clk_100);
        i_rst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            run_op(op_q[i], name_q[i], arg_a_q[i], arg_b_q[i]);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // heartbeat and phy reset, counted in edges since release
    initial begin
        int since;
        since = 0;
        @(posedge i_rst_n);
        forever begin
            @(negedge clk_100);
            since++;
            check_value("heartbeat_led", {63'd0, since[LED_DIV_BIT]}, {63'd0, o_usr_led});
            check_value("phy_resetn", {63'd0, since >= (2 ** PHY_RST_WIDTH) - 1},
                        {63'd0, o_phy_resetn});
        end
    end

    initial begin
        cycles = 0;
        @(posedge clk_100);
        while (limit == 0 || cycles < limit) begin
            @(posedge clk_100);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycles);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== verification/serdes_golden.txt ====
# columns: op name arg_a arg_b, args in hex; wr addr data, rd addr expect, rx chan word
# pn pin expect (0 a_ctrl 1 b_ctrl 2 a_tx 3 b_tx 4 a_loss 5 b_loss 6 rdata), wt cycles 0
pn rst_a_ctrl 0 01
pn rst_b_ctrl 1 01
pn rst_a_tx 2 0
pn rst_b_tx 3 0
pn rst_a_loss 4 0
pn rst_b_loss 5 0
pn rst_rdata 6 0
wr a_ctrl_wr 0100 ffff00000000002b
wt a_ctrl_settle 1 0
pn a_ctrl_pins 0 2b
pn b_ctrl_kept 1 01
rd a_ctrl_rd 0100 2b
rd b_ctrl_rd 0000 01
wr b_tx_wr 0001 2beef
wt b_tx_settle 1 0
pn b_tx_pins 3 2beef
pn a_tx_kept 2 0
rd b_tx_rd 0001 2beef
wr miss_wr 0200 3f
wt miss_settle 1 0
pn miss_a_ctrl 0 2b
pn miss_b_ctrl 1 01
rd miss_rd 0200 0
rd a_ofs3_rd 0103 0
rx a_rx_k 0 1abcd
wt a_rx_settle a 0
rd a_rx_rd 0102 1abcd
rx a_rx_nok 0 01234
wt a_loss_settle 14 0
pn a_loss_irq 4 1
pn b_loss_quiet 5 0
rd a_loss_rd 0102 41234
rx a_rx_k2 0 20055
wt a_clear_settle a 0
pn a_loss_clear 4 0
rd a_clear_rd 0102 20055
rx b_rx_nok 1 00777
wt b_loss_settle 14 0
pn b_loss_irq 5 1
pn a_loss_quiet 4 0
rd b_loss_rd 0002 40777

// ==== tb.f ====
logic/host_bus_pkg.sv
logic/tlk_pkg.sv
logic/board_support.sv
logic/tlk_rx_sync.sv
logic/link_ctrl_regs.sv
logic/host_reg_decode.sv
logic/serdes_top.sv
verification/serdes_top_assert.sv
verification/tb_serdes_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the serdes testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_serdes_top \
    -f tb.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
